// ==== compile.f ====
+incdir+dv
source/timekeeper_pkg.sv
source/tick_divider.sv
source/time_digit_counter.sv
source/time_chain.sv
source/watch_adjust_decoder.sv
source/stopwatch_control.sv
source/timekeeper_top.sv
dv/timekeeper_tb.sv

// ==== Makefile ====
TOP := timekeeper_tb

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== dv/timekeeper_testdata.txt ====
# H hold | A field step count | S start_stop | C clear | I idle cycles | R running flag
# W watch, T stopwatch expected as hh mm ss cc; field 0..3 hour..centi; step 1 +1 2 +10 3 -1 4 -10
W 12 0 0 0
T 0 0 0 0
R 0
# adjust under hold with wraps
A 0 4 1
A 0 3 3
A 1 3 5
A 1 2 1
A 3 1 3
A 3 4 1
A 2 3 1
A 2 1 1
W 23 5 0 93
# adjust with hold low is dropped, one running cycle gives no tick
H 0
A 3 1 1
H 1
W 23 5 0 93
# preset to 23 59 59 98
A 1 4 1
A 1 1 4
A 2 3 1
A 3 1 5
W 23 59 59 98
# eight running cycles ripple to midnight
H 0
I 8
H 1
W 0 0 0 0
# stopwatch runs of 40 and 21 cycles
S
R 1
I 39
S
R 0
T 0 0 0 10
S
R 1
I 20
S
R 0
T 0 0 0 15
# clear while running ignored, 20 cycles run
S
I 9
C
I 9
S
T 0 0 0 20
# clear while stopped
C
T 0 0 0 0
R 0
# 24000 cycles is one minute
S
I 23999
S
R 0
T 0 1 0 0
W 0 0 0 0

// ==== dv/timekeeper_checks.svh ====
`ifndef TIMEKEEPER_CHECKS_SVH
`define TIMEKEEPER_CHECKS_SVH

// time value as hh:mm:ss.cc for error lines
function automatic string time_text(input timekeeper_pkg::time_t t);
    return $sformatf("%02d:%02d:%02d.%02d", t.hour, t.min, t.sec, t.centi);
endfunction

task automatic compare_time(input timekeeper_pkg::time_t got,
                            input timekeeper_pkg::time_t exp,
                            input string name);
    if (got !== exp) begin
        $display("FAILED t=%0t %s expected %s got %s",
                 $time, name, time_text(exp), time_text(got));
        $display("TEST FAILED");
        $fatal(1, "first mismatch on a time output");
    end
endtask

task automatic compare_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, got);
        $display("TEST FAILED");
        $fatal(1, "first mismatch on a flag output");
    end
endtask

`endif

// ==== dv/timekeeper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module timekeeper_tb;

    // short prescaler, one centisecond per four running cycles
    localparam int TICK_DIVIDE   = 4;
    localparam int SETTLE_CYCLES = 6;

    logic                        clk;
    logic                        rst;
    logic                        i_watch_hold;
    timekeeper_pkg::adjust_cmd_t i_adjust;
    timekeeper_pkg::sw_cmd_t     i_sw_cmd;
    timekeeper_pkg::time_t       o_watch_time;
    timekeeper_pkg::time_t       o_sw_time;
    logic                        o_sw_running;

    timekeeper_top #(
        .TICK_DIVIDE(TICK_DIVIDE)
    ) timekeeper_top_i (
        .clk         (clk),
        .rst         (rst),
        .i_watch_hold(i_watch_hold),
        .i_adjust    (i_adjust),
        .i_sw_cmd    (i_sw_cmd),
        .o_watch_time(o_watch_time),
        .o_sw_time   (o_sw_time),
        .o_sw_running(o_sw_running)
    );

    `include "timekeeper_checks.svh"

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
        end
    endtask

    // both chains stopped here, random gap on top
    task automatic settle();
        idle(SETTLE_CYCLES + int'($urandom % 4));
    endtask

    // one strobe per cycle, repeats back to back
    task automatic pulse_adjust(input int field, input int step, input int repeats);
        i_adjust.field = timekeeper_pkg::time_field_e'(field);
        i_adjust.step  = timekeeper_pkg::step_e'(step);
        for (int i = 0; i < repeats; i++) begin
            i_adjust.valid = 1'b1;
            @(negedge clk);
        end
        i_adjust = '0;
    endtask

    task automatic pulse_sw_cmd(input logic start_stop, input logic clear);
        i_sw_cmd.start_stop = start_stop;
        i_sw_cmd.clear      = clear;
        @(negedge clk);
        i_sw_cmd = '0;
    endtask

    function automatic timekeeper_pkg::time_t make_time(input int h, input int m,
                                                         input int s, input int c);
        timekeeper_pkg::time_t t;
        t.hour  = timekeeper_pkg::hour_t'(h);
        t.min   = timekeeper_pkg::min_t'(m);
        t.sec   = timekeeper_pkg::sec_t'(s);
        t.centi = timekeeper_pkg::centi_t'(c);
        return t;
    endfunction

    // opcode in the first column, up to four numbers after it
    task automatic run_commands(input int fd);
        string line;
        byte   op;
        int    a;
        int    b;
        int    c;
        int    d;
        while ($fgets(line, fd) != 0) begin
            op = line.getc(0);
            // comment and empty lines skipped
            if (op != "#" && op != "\n") begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %d", a, b, c, d));
                case (op)
                    "H": i_watch_hold = a[0];
                    "A": pulse_adjust(a, b, c);
                    "S": pulse_sw_cmd(1'b1, 1'b0);
                    "C": pulse_sw_cmd(1'b0, 1'b1);
                    "I": idle(a);
                    "W": begin
                        settle();
                        compare_time(o_watch_time, make_time(a, b, c, d), "o_watch_time");
                    end
                    "T": begin
                        settle();
                        compare_time(o_sw_time, make_time(a, b, c, d), "o_sw_time");
                    end
                    "R": begin
                        // flag already follows the strobe one edge later
                        compare_flag(o_sw_running, a[0], "o_sw_running");
                    end
                    default: begin
                        $display("unknown command in the stimulus file: %s", line);
                        $display("TEST FAILED");
                        $fatal(1, "bad stimulus line");
                    end
                endcase
            end
        end
    endtask

    initial begin
        int fd;
        void'($urandom(32'h595977fe));
        rst          = 1'b1;
        // watch frozen from the start
        i_watch_hold = 1'b1;
        i_adjust     = '0;
        i_sw_cmd     = '0;
        repeat (16) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("dv/timekeeper_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/timekeeper_testdata.txt for reading");
            $display("TEST FAILED");
            $fatal(1, "no stimulus file");
        end else begin
            run_commands(fd);
            $fclose(fd);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/timekeeper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module timekeeper_top #(
    parameter int TICK_DIVIDE = 1_000_000
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_watch_hold,
    input  timekeeper_pkg::adjust_cmd_t i_adjust,
    input  timekeeper_pkg::sw_cmd_t     i_sw_cmd,
    output timekeeper_pkg::time_t       o_watch_time,
    output timekeeper_pkg::time_t       o_sw_time,
    output logic                        o_sw_running
);
    // watch side
    timekeeper_pkg::field_steps_t watch_steps;
    logic                         watch_run;

    // stopwatch side, run enable is o_sw_running
    timekeeper_pkg::field_steps_t sw_steps;

    watch_adjust_decoder watch_adjust_decoder_i (
        .clk     (clk),
        .rst     (rst),
        .i_hold  (i_watch_hold),
        .i_adjust(i_adjust),
        .o_steps (watch_steps),
        .o_run   (watch_run)
    );

    stopwatch_control stopwatch_control_i (
        .clk      (clk),
        .rst      (rst),
        .i_cmd    (i_sw_cmd),
        .o_steps  (sw_steps),
        .o_running(o_sw_running)
    );

    // watch starts at noon
    time_chain #(
        .TICK_DIVIDE(TICK_DIVIDE),
        .HOUR_INIT  (timekeeper_pkg::WATCH_HOUR_INIT)
    ) watch_chain_i (
        .clk    (clk),
        .rst    (rst),
        .i_run  (watch_run),
        .i_steps(watch_steps),
        .o_time (o_watch_time)
    );

    // stopwatch starts at zero
    time_chain #(
        .TICK_DIVIDE(TICK_DIVIDE),
        .HOUR_INIT  (timekeeper_pkg::SW_HOUR_INIT)
    ) sw_chain_i (
        .clk    (clk),
        .rst    (rst),
        .i_run  (o_sw_running),
        .i_steps(sw_steps),
        .o_time (o_sw_time)
    );

endmodule

`default_nettype wire

// ==== source/stopwatch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module stopwatch_control (
    input  logic                         clk,
    input  logic                         rst,
    input  timekeeper_pkg::sw_cmd_t      i_cmd,
    output timekeeper_pkg::field_steps_t o_steps,
    output logic                         o_running
);
    timekeeper_pkg::sw_state_e state_q;
    timekeeper_pkg::sw_state_e state_next;
    logic                      clear_ok;

    always_comb begin
        state_next = state_q;
        // start_stop flips the run state
        if (i_cmd.start_stop) begin
            if (state_q == timekeeper_pkg::SW_RUNNING) begin
                state_next = timekeeper_pkg::SW_STOPPED;
            end else begin
                state_next = timekeeper_pkg::SW_RUNNING;
            end
        end
        // clear only when stopped, and start_stop wins a tie
        clear_ok = i_cmd.clear && !i_cmd.start_stop &&
                   (state_q == timekeeper_pkg::SW_STOPPED);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= timekeeper_pkg::SW_STOPPED;
            o_steps <= '{default: timekeeper_pkg::STEP_NONE};
        end else begin
            state_q <= state_next;
            if (clear_ok) begin
                // zero all four fields in one pulse
                o_steps <= '{default: timekeeper_pkg::STEP_CLEAR};
            end else begin
                o_steps <= '{default: timekeeper_pkg::STEP_NONE};
            end
        end
    end

    assign o_running = (state_q == timekeeper_pkg::SW_RUNNING);

    // a clear pulse lands only on a chain that was and still is stopped
    a_no_clear_running: assert property (@(posedge clk) disable iff (rst)
        (o_steps.centi == timekeeper_pkg::STEP_CLEAR) |->
            (!o_running && $past(state_q) == timekeeper_pkg::SW_STOPPED));

endmodule

`default_nettype wire

// ==== source/watch_adjust_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module watch_adjust_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_hold,
    input  timekeeper_pkg::adjust_cmd_t  i_adjust,
    output timekeeper_pkg::field_steps_t o_steps,
    output logic                         o_run
);
    timekeeper_pkg::step_e        step_req;
    timekeeper_pkg::field_steps_t steps_next;

    always_comb begin
        // only the four adjust steps pass, clear is stopwatch-only
        case (i_adjust.step)
            timekeeper_pkg::STEP_INC1,
            timekeeper_pkg::STEP_INC10,
            timekeeper_pkg::STEP_DEC1,
            timekeeper_pkg::STEP_DEC10: step_req = i_adjust.step;
            default: step_req = timekeeper_pkg::STEP_NONE;
        endcase

        steps_next = '{default: timekeeper_pkg::STEP_NONE};
        // strobes outside hold are dropped
        if (i_hold && i_adjust.valid) begin
            case (i_adjust.field)
                timekeeper_pkg::FIELD_HOUR:  steps_next.hour  = step_req;
                timekeeper_pkg::FIELD_MIN:   steps_next.min   = step_req;
                timekeeper_pkg::FIELD_SEC:   steps_next.sec   = step_req;
                timekeeper_pkg::FIELD_CENTI: steps_next.centi = step_req;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_steps <= '{default: timekeeper_pkg::STEP_NONE};
            // watch free-runs out of reset
            o_run   <= 1'b1;
        end else begin
            o_steps <= steps_next;
            o_run   <= ~i_hold;
        end
    end

    // one field per adjust pulse
    a_one_field: assert property (@(posedge clk) disable iff (rst)
        $countones({o_steps.hour  != timekeeper_pkg::STEP_NONE,
                    o_steps.min   != timekeeper_pkg::STEP_NONE,
                    o_steps.sec   != timekeeper_pkg::STEP_NONE,
                    o_steps.centi != timekeeper_pkg::STEP_NONE}) <= 1);

endmodule

`default_nettype wire

// ==== source/time_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_chain #(
    parameter int TICK_DIVIDE = 1_000_000,
    parameter int HOUR_INIT   = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_run,
    input  timekeeper_pkg::field_steps_t i_steps,
    output timekeeper_pkg::time_t        o_time
);
    // 100 Hz tick, then one carry per field boundary
    logic tick;
    logic centi_carry;
    logic sec_carry;
    logic min_carry;

    timekeeper_pkg::centi_t centi_value;
    timekeeper_pkg::sec_t   sec_value;
    timekeeper_pkg::min_t   min_value;
    timekeeper_pkg::hour_t  hour_value;

    tick_divider #(
        .TICK_DIVIDE(TICK_DIVIDE)
    ) tick_divider_i (
        .clk   (clk),
        .rst   (rst),
        .i_run (i_run),
        .o_tick(tick)
    );

    time_digit_counter #(
        .MODULUS(timekeeper_pkg::CENTI_MOD),
        .WIDTH  ($bits(timekeeper_pkg::centi_t)),
        .INIT   (0)
    ) centi_counter_i (
        .clk    (clk),
        .rst    (rst),
        .i_carry(tick),
        .i_step (i_steps.centi),
        .o_value(centi_value),
        .o_carry(centi_carry)
    );

    time_digit_counter #(
        .MODULUS(timekeeper_pkg::SEC_MOD),
        .WIDTH  ($bits(timekeeper_pkg::sec_t)),
        .INIT   (0)
    ) sec_counter_i (
        .clk    (clk),
        .rst    (rst),
        .i_carry(centi_carry),
        .i_step (i_steps.sec),
        .o_value(sec_value),
        .o_carry(sec_carry)
    );

    time_digit_counter #(
        .MODULUS(timekeeper_pkg::MIN_MOD),
        .WIDTH  ($bits(timekeeper_pkg::min_t)),
        .INIT   (0)
    ) min_counter_i (
        .clk    (clk),
        .rst    (rst),
        .i_carry(sec_carry),
        .i_step (i_steps.min),
        .o_value(min_value),
        .o_carry(min_carry)
    );

    // top field, wrap past 23 goes nowhere
    time_digit_counter #(
        .MODULUS(timekeeper_pkg::HOUR_MOD),
        .WIDTH  ($bits(timekeeper_pkg::hour_t)),
        .INIT   (HOUR_INIT)
    ) hour_counter_i (
        .clk    (clk),
        .rst    (rst),
        .i_carry(min_carry),
        .i_step (i_steps.hour),
        .o_value(hour_value),
        .o_carry()
    );

    assign o_time = '{
        hour:  hour_value,
        min:   min_value,
        sec:   sec_value,
        centi: centi_value
    };

endmodule

`default_nettype wire

// ==== source/time_digit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_digit_counter #(
    parameter int MODULUS = 60,
    parameter int WIDTH   = 6,
    parameter int INIT    = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_carry,
    input  timekeeper_pkg::step_e i_step,
    output logic [WIDTH-1:0]      o_value,
    output logic                  o_carry
);
    // one spare bit so value plus ten cannot overflow before the wrap check
    localparam logic [WIDTH:0] MOD_EXT = (WIDTH + 1)'(MODULUS);
    localparam logic [WIDTH:0] LAST    = (WIDTH + 1)'(MODULUS - 1);
    localparam logic [WIDTH:0] ONE     = (WIDTH + 1)'(1);
    localparam logic [WIDTH:0] TEN     = (WIDTH + 1)'(10);

    logic [WIDTH-1:0] value_q;
    logic [WIDTH:0]   value_ext;
    logic [WIDTH:0]   value_next;
    logic             carry_next;

    assign value_ext = {1'b0, value_q};
    assign o_value   = value_q;

    always_comb begin
        value_next = value_ext;
        // wrap seen on the tick path, kept even when a step wins the value
        carry_next = i_carry && (value_ext == LAST);
        case (i_step)
            timekeeper_pkg::STEP_CLEAR: begin
                value_next = '0;
            end
            timekeeper_pkg::STEP_INC1: begin
                value_next = (value_ext == LAST) ? '0 : value_ext + ONE;
            end
            timekeeper_pkg::STEP_INC10: begin
                // past the top, fold back by one modulus
                if (value_ext + TEN >= MOD_EXT) begin
                    value_next = value_ext + TEN - MOD_EXT;
                end else begin
                    value_next = value_ext + TEN;
                end
            end
            timekeeper_pkg::STEP_DEC1: begin
                value_next = (value_ext == '0) ? LAST : value_ext - ONE;
            end
            timekeeper_pkg::STEP_DEC10: begin
                // below zero, borrow one modulus
                if (value_ext < TEN) begin
                    value_next = value_ext + MOD_EXT - TEN;
                end else begin
                    value_next = value_ext - TEN;
                end
            end
            default: begin
                // no step, plain count on carry in
                if (i_carry) begin
                    value_next = (value_ext == LAST) ? '0 : value_ext + ONE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            value_q <= WIDTH'(INIT);
            o_carry <= 1'b0;
        end else begin
            value_q <= value_next[WIDTH-1:0];
            o_carry <= carry_next;
        end
    end

    // field never leaves its range, whatever mix of steps and carries
    a_value_in_range: assert property (@(posedge clk) disable iff (rst)
        value_ext < MOD_EXT);

endmodule

`default_nettype wire

// ==== source/tick_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
    parameter int TICK_DIVIDE = 1_000_000
) (
    input  logic clk,
    input  logic rst,
    input  logic i_run,
    output logic o_tick
);
    // at least one bit, so a divide by one still builds
    localparam int CNT_W = (TICK_DIVIDE > 1) ? $clog2(TICK_DIVIDE) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIVIDE - 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_q <= '0;
            o_tick  <= 1'b0;
        end else if (!i_run) begin
            // stopped chain restarts its period from zero
            count_q <= '0;
            o_tick  <= 1'b0;
        end else if (count_q == CNT_LAST) begin
            // last cycle of the period
            count_q <= '0;
            o_tick  <= 1'b1;
        end else begin
            count_q <= count_q + CNT_W'(1);
            o_tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/timekeeper_pkg.sv ====
`default_nettype none

package timekeeper_pkg;

    // field value vectors
    typedef logic [6:0] centi_t;
    typedef logic [5:0] sec_t;
    typedef logic [5:0] min_t;
    typedef logic [4:0] hour_t;

    // field moduli
    localparam int CENTI_MOD = 100;
    localparam int SEC_MOD   = 60;
    localparam int MIN_MOD   = 60;
    localparam int HOUR_MOD  = 24;

    // hour after reset, per chain
    localparam int WATCH_HOUR_INIT = 12;
    localparam int SW_HOUR_INIT    = 0;

    // field addressed by an adjust
    typedef enum logic [1:0] {
        FIELD_HOUR,
        FIELD_MIN,
        FIELD_SEC,
        FIELD_CENTI
    } time_field_e;

    // command to one field counter
    typedef enum logic [2:0] {
        STEP_NONE,
        STEP_INC1,
        STEP_INC10,
        STEP_DEC1,
        STEP_DEC10,
        STEP_CLEAR
    } step_e;

    typedef enum logic {
        SW_STOPPED,
        SW_RUNNING
    } sw_state_e;

    // per-field commands into a chain
    typedef struct packed {
        step_e hour;
        step_e min;
        step_e sec;
        step_e centi;
    } field_steps_t;

    // hour in the top bits
    typedef struct packed {
        hour_t  hour;
        min_t   min;
        sec_t   sec;
        centi_t centi;
    } time_t;

    typedef struct packed {
        logic        valid;
        time_field_e field;
        step_e       step;
    } adjust_cmd_t;

    typedef struct packed {
        logic start_stop;
        logic clear;
    } sw_cmd_t;

endpackage

`default_nettype wire
